// ==== logic/exLanePkg.sv ====
// Shared encodings and bundles for the secondary execute lane.
// Command and extension codes are local to this lane and not a full ISA map.
package exLanePkg;

	// Condition codes in uop.cond
	localparam logic [1:0] condAlways = 2'b00;
	localparam logic [1:0] condNever  = 2'b01;
	localparam logic [1:0] condTrue   = 2'b10; // Run if T set
	localparam logic [1:0] condFalse  = 2'b11; // Run if T clear

	// Micro-op commands
	localparam logic [5:0] cmdNop     = 6'h00;
	localparam logic [5:0] cmdInvOp   = 6'h01;
	localparam logic [5:0] cmdMovRm   = 6'h02; // Store of Rs
	localparam logic [5:0] cmdPushX   = 6'h03; // Store of Rm
	localparam logic [5:0] cmdAlu3    = 6'h04;
	localparam logic [5:0] cmdUnary   = 6'h05;
	localparam logic [5:0] cmdMulw3   = 6'h06;
	localparam logic [5:0] cmdConvRr  = 6'h07;
	localparam logic [5:0] cmdMovIr   = 6'h08;
	localparam logic [5:0] cmdShad3   = 6'h09;
	localparam logic [5:0] cmdShld3   = 6'h0A;
	localparam logic [5:0] cmdShadq3  = 6'h0B;
	localparam logic [5:0] cmdShldq3  = 6'h0C;
	localparam logic [5:0] cmdOpIxs   = 6'h0D;
	localparam logic [5:0] cmdOpIxt   = 6'h0E;

	// Extension codes, compared against ixt[5:0]
	localparam logic [5:0] ixsNop     = 6'h00;
	localparam logic [5:0] ixsMovt    = 6'h01;
	localparam logic [5:0] ixsMovnt   = 6'h02;
	localparam logic [5:0] ixtNop     = 6'h00;
	localparam logic [5:0] ixtSleep   = 6'h01;
	localparam logic [5:0] ixtBreak   = 6'h02;

	// MOV_IR forms in ixt[3:0]
	localparam logic [3:0] movIrLdi   = 4'h0;
	localparam logic [3:0] movIrSh8   = 4'h1;
	localparam logic [3:0] movIrSh16  = 4'h2;
	localparam logic [3:0] movIrSh32  = 4'h3;

	localparam logic [5:0] zeroRegId  = 6'd63; // No register write

	typedef struct packed {
		logic [1:0] cond;
		logic [5:0] cmd;
		logic [7:0] ixt; // Upper two bits reserved
	} exUop;

	typedef struct packed {
		logic [5:0]  rsId;
		logic [5:0]  rtId;
		logic [5:0]  rmId;
		logic [63:0] rsVal;
		logic [63:0] rtVal;
		logic [63:0] rmVal;
		logic [32:0] imm; // Bit 32 is the sign
	} exOperands;

	typedef struct packed {
		logic [5:0]  destId;
		logic [63:0] value;
		logic [5:0]  heldId; // Completed by a later stage
	} exResult;

	typedef struct packed {
		logic [5:0] cmd;
		logic [7:0] ixt;
	} exFault;

	localparam exResult resultNone = '{destId: zeroRegId, value: 64'd0, heldId: zeroRegId};

endpackage

// ==== logic/exShifter.sv ====
// Combinational barrel shift by a signed 8-bit amount; negative shifts right.
// Magnitudes at or past the word width saturate to 0 or all sign bits.
`timescale 1ns/1ps

module exShifter #(
	parameter type wordType = logic [31:0]
) (
	input  wordType    value,
	input  logic [7:0] amount,
	input  logic       arithmetic,
	output wordType    shifted
);

	logic [8:0]                 magnitude;
	logic [$bits(wordType)-1:0] word;
	logic [$bits(wordType)-1:0] fill;
	logic [$bits(wordType)-1:0] outWord;
	logic                       signBit;
	logic                       outOfRange;

	always_comb begin
		word    = value;
		signBit = arithmetic & word[$bits(wordType)-1];
		fill    = {$bits(wordType){signBit}};

		// -128 needs the ninth bit
		if (amount[7]) begin
			magnitude = 9'd256 - {1'b0, amount};
		end else begin
			magnitude = {1'b0, amount};
		end
		outOfRange = magnitude >= 9'($bits(wordType));

		if (!amount[7]) begin
			if (outOfRange) begin
				outWord = '0;
			end else begin
				outWord = word << magnitude;
			end
		end else if (outOfRange) begin
			outWord = fill; // Everything shifted out
		end else if (arithmetic) begin
			outWord = $signed(word) >>> magnitude;
		end else begin
			outWord = word >> magnitude;
		end
	end

	assign shifted = wordType'(outWord);

endmodule

// ==== logic/exConvert.sv ====
// Sign or zero extension of the low byte, word or dword of a 64-bit value.
// Modes 6 and 7 pass the value through and so always report unchanged.
`timescale 1ns/1ps

module exConvert (
	input  logic [63:0] value,
	input  logic [2:0]  mode,
	output logic [63:0] converted,
	output logic        unchanged
);

	always_comb begin
		case (mode)
			3'd0: begin
				converted = {{56{value[7]}}, value[7:0]}; // Sign byte
			end
			3'd1: begin
				converted = {56'd0, value[7:0]}; // Zero byte
			end
			3'd2: begin
				converted = {{48{value[15]}}, value[15:0]};
			end
			3'd3: begin
				converted = {48'd0, value[15:0]};
			end
			3'd4: begin
				converted = {{32{value[31]}}, value[31:0]};
			end
			3'd5: begin
				converted = {32'd0, value[31:0]};
			end
			default: begin
				converted = value; // Pass-through codes
			end
		endcase
	end

	// Value already fit the selected form
	assign unchanged = (converted == value);

endmodule

// ==== logic/exStatusReg.sv ====
// T bit and sticky first-fault record; the lane's T write beats an external write.
// The fault payload is only meaningful while faultValid is high.
`timescale 1ns/1ps

module exStatusReg import exLanePkg::*; (
	input  logic   clock,
	input  logic   reset,
	input  logic   statusWrite,
	input  logic   statusValue,
	input  logic   laneTWrite,
	input  logic   laneTValue,
	input  logic   faultStrobe,
	input  exFault faultIn,
	output logic   tBit,
	output logic   faultValid,
	output exFault fault
);

	always_ff @(posedge clock) begin
		if (reset) begin
			tBit <= 1'b0;
		end else if (laneTWrite) begin
			tBit <= laneTValue; // Lane has priority
		end else if (statusWrite) begin
			tBit <= statusValue;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			faultValid <= 1'b0;
		end else if (faultStrobe) begin
			faultValid <= 1'b1; // Sticky until reset
		end
	end

	// Capture only while no fault is recorded yet
	always_ff @(posedge clock) begin
		if (!reset && faultStrobe && !faultValid) begin
			fault <= faultIn;
		end
	end

endmodule

// ==== logic/exLaneB.sv ====
// First execute stage of the secondary lane; one op per cycle, no stall input.
// ALU and multiply ops only name their held destination here.
`timescale 1ns/1ps

module exLaneB import exLanePkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  exUop        uop,
	input  exOperands   operands,
	input  logic        braFlush,
	input  logic        tBit,
	input  logic [31:0] shift32,
	input  logic [63:0] shift64,
	input  logic [63:0] converted,
	input  logic        unchanged,
	output logic        shiftArith,
	output logic        laneTWrite,
	output logic        laneTValue,
	output logic        faultStrobe,
	output exFault      faultOut,
	output logic        hold,
	output exResult     result
);

	logic       opEnable;
	logic [5:0] activeCmd;
	logic       faultDetect;
	exResult    nextResult;

	always_comb begin
		case (uop.cond)
			condAlways: opEnable = 1'b1;
			condTrue:   opEnable = tBit;
			condFalse:  opEnable = !tBit;
			default:    opEnable = 1'b0; // Never
		endcase
		if (braFlush) begin
			opEnable = 1'b0;
		end
		activeCmd = opEnable ? uop.cmd : cmdNop;
	end

	// Both shifters share one mode line
	assign shiftArith = (uop.cmd == cmdShad3) || (uop.cmd == cmdShadq3);

	always_comb begin
		nextResult  = resultNone;
		faultDetect = 1'b0;
		laneTWrite  = 1'b0;
		laneTValue  = unchanged;

		case (activeCmd)
			cmdNop: begin
			end
			cmdMovRm: begin
				nextResult.value = operands.rsVal; // Store data, no reg write
			end
			cmdPushX: begin
				nextResult.value = operands.rmVal;
			end
			cmdAlu3, cmdUnary, cmdMulw3: begin
				nextResult.heldId = operands.rmId;
			end
			cmdConvRr: begin
				nextResult.destId = operands.rmId;
				nextResult.value  = converted;
				laneTWrite        = 1'b1;
			end
			cmdMovIr: begin
				nextResult.destId = operands.rmId;
				case (uop.ixt[3:0])
					movIrLdi: begin
						nextResult.value = {{32{operands.imm[32]}}, operands.imm[31:0]};
					end
					movIrSh8: begin
						nextResult.value = {operands.rsVal[55:0], operands.imm[7:0]};
					end
					movIrSh16: begin
						nextResult.value = {operands.rsVal[47:0], operands.imm[15:0]};
					end
					movIrSh32: begin
						nextResult.value = {operands.rsVal[31:0], operands.imm[31:0]};
					end
					default: begin
						nextResult.value = operands.rtVal; // Unknown form
					end
				endcase
			end
			cmdShad3: begin
				nextResult.destId = operands.rmId;
				nextResult.value  = {{32{shift32[31]}}, shift32};
			end
			cmdShld3: begin
				nextResult.destId = operands.rmId;
				nextResult.value  = {32'd0, shift32};
			end
			cmdShadq3, cmdShldq3: begin
				nextResult.destId = operands.rmId;
				nextResult.value  = shift64;
			end
			cmdOpIxs: begin
				case (uop.ixt[5:0])
					ixsNop: begin
					end
					ixsMovt: begin
						nextResult.destId = operands.rmId;
						nextResult.value  = {63'd0, tBit};
					end
					ixsMovnt: begin
						nextResult.destId = operands.rmId;
						nextResult.value  = {63'd0, !tBit};
					end
					default: begin
						faultDetect = 1'b1;
					end
				endcase
			end
			cmdOpIxt: begin
				case (uop.ixt[5:0])
					ixtNop, ixtSleep: begin
					end
					default: begin
						faultDetect = 1'b1; // BREAK or unhandled
					end
				endcase
			end
			default: begin
				faultDetect = 1'b1; // InvOp and unknown commands
			end
		endcase
	end

	assign faultStrobe = faultDetect;
	assign faultOut    = '{cmd: uop.cmd, ixt: uop.ixt};
	assign hold        = faultDetect && !reset; // Same cycle as the fault

	always_ff @(posedge clock) begin
		if (reset) begin
			result <= resultNone;
		end else begin
			result <= nextResult;
		end
	end

endmodule

// ==== logic/exLaneTop.sv ====
// Secondary execute lane with its shifters, converter and status block.
// Inputs are sampled every cycle; hold is advisory and stalls nothing.
`timescale 1ns/1ps

module exLaneTop import exLanePkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  exUop      uop,
	input  exOperands operands,
	input  logic      braFlush,
	input  logic      statusWrite,
	input  logic      statusValue,
	output exResult   result,
	output logic      hold,
	output logic      tBit,
	output logic      faultValid,
	output exFault    fault
);

	logic [31:0] shift32;
	logic [63:0] shift64;
	logic [63:0] converted;
	logic        unchanged;
	logic        shiftArith;
	logic        laneTWrite;
	logic        laneTValue;
	logic        faultStrobe;
	exFault      faultOut;

	exLaneB laneB (
		.clock(clock),
		.reset(reset),
		.uop(uop),
		.operands(operands),
		.braFlush(braFlush),
		.tBit(tBit),
		.shift32(shift32),
		.shift64(shift64),
		.converted(converted),
		.unchanged(unchanged),
		.shiftArith(shiftArith),
		.laneTWrite(laneTWrite),
		.laneTValue(laneTValue),
		.faultStrobe(faultStrobe),
		.faultOut(faultOut),
		.hold(hold),
		.result(result)
	);

	exShifter #(.wordType(logic [31:0])) shifter32 (
		.value(operands.rsVal[31:0]),
		.amount(operands.rtVal[7:0]),
		.arithmetic(shiftArith),
		.shifted(shift32)
	);

	exShifter #(.wordType(logic [63:0])) shifter64 (
		.value(operands.rsVal),
		.amount(operands.rtVal[7:0]),
		.arithmetic(shiftArith),
		.shifted(shift64)
	);

	exConvert convert (
		.value(operands.rsVal),
		.mode(uop.ixt[2:0]),
		.converted(converted),
		.unchanged(unchanged)
	);

	exStatusReg statusReg (
		.clock(clock),
		.reset(reset),
		.statusWrite(statusWrite),
		.statusValue(statusValue),
		.laneTWrite(laneTWrite),
		.laneTValue(laneTValue),
		.faultStrobe(faultStrobe),
		.faultIn(faultOut),
		.tBit(tBit),
		.faultValid(faultValid),
		.fault(fault)
	);

endmodule

// ==== tests/exLaneAsserts.sv ====
// Concurrent checks on the lane top level, attached by bind.
// A store op may leave a value on a no-write result; only that case is exempt.
`timescale 1ns/1ps

module exLaneAsserts import exLanePkg::*; (
	input logic    clock,
	input logic    reset,
	input exUop    uop,
	input logic    hold,
	input logic    faultValid,
	input exResult result
);

	logic wasStore; // Previous op was MovRm or PushX

	always_ff @(posedge clock) begin
		wasStore <= !reset && ((uop.cmd == cmdMovRm) || (uop.cmd == cmdPushX));
	end

	holdLowInReset: assert property (@(posedge clock) reset |-> !hold)
		else $error("hold raised while reset is high");

	faultSticky: assert property (@(posedge clock) disable iff (reset) faultValid |=> faultValid)
		else $error("faultValid fell without reset");

	noWriteZero: assert property (@(posedge clock) disable iff (reset)
		(result.destId == zeroRegId && !wasStore) |-> result.value == 64'd0)
		else $error("no-write result carries a nonzero value");

endmodule

bind exLaneTop exLaneAsserts laneAsserts (
	.clock(clock),
	.reset(reset),
	.uop(uop),
	.hold(hold),
	.faultValid(faultValid),
	.result(result)
);

// ==== tests/exLaneTb.sv ====
// Directed table plus LCG random shifts against a bit-level shift model.
// Inputs change 1 ns after the rising edge; results are sampled 1 ns after.
`timescale 1ns/1ps

module exLaneTb import exLanePkg::*; ;

	typedef struct {
		logic      setT;
		logic      tVal;
		exUop      uop;
		exOperands ops;
		logic      flush;
		exResult   expRes;
		logic      expHold;
		logic      expT;
	} entryT;

	logic      clock;
	logic      reset;
	exUop      uop;
	exOperands operands;
	logic      braFlush;
	logic      statusWrite;
	logic      statusValue;
	exResult   result;
	logic      hold;
	logic      tBit;
	logic      faultValid;
	exFault    fault;

	entryT       entries[$];
	logic [31:0] lcgState = 32'h5909_0ba6;
	logic        faultSeen; // Set once a faulting op has been applied

	exLaneTop i_dut (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Bit by bit model of the shift rule for a given width
	function automatic logic [63:0] shiftModel(input logic [63:0] v, input logic [7:0] amt,
			input logic arith, input int width);
		int          a;
		int          src;
		logic        sign;
		logic [63:0] r;
		a    = $signed(amt);
		sign = arith & v[width-1];
		r    = '0;
		for (int i = 0; i < width; i++) begin
			if (a >= 0) begin
				src  = i - a;
				r[i] = (src >= 0) ? v[src] : 1'b0;
			end else begin
				src  = i - a;
				r[i] = (src < width) ? v[src] : sign;
			end
		end
		if (width == 32) begin
			r[63:32] = arith ? {32{r[31]}} : 32'd0;
		end
		return r;
	endfunction

	function automatic exOperands makeOps(input logic [63:0] rs, input logic [63:0] rt,
			input logic [63:0] rm, input logic [32:0] imm, input logic [5:0] rmId);
		exOperands o;
		o.rsId  = 6'd1;
		o.rtId  = 6'd2;
		o.rmId  = rmId;
		o.rsVal = rs;
		o.rtVal = rt;
		o.rmVal = rm;
		o.imm   = imm;
		return o;
	endfunction

	task automatic addEntry(input logic setT, input logic tVal, input logic [1:0] cond,
			input logic [5:0] cmd, input logic [7:0] ixt, input exOperands ops,
			input logic flush, input logic [5:0] dest, input logic [63:0] val,
			input logic [5:0] held, input logic expHold, input logic expT);
		entryT e;
		e.setT    = setT;
		e.tVal    = tVal;
		e.uop     = '{cond: cond, cmd: cmd, ixt: ixt};
		e.ops     = ops;
		e.flush   = flush;
		e.expRes  = '{destId: dest, value: val, heldId: held};
		e.expHold = expHold;
		e.expT    = expT;
		entries.push_back(e);
	endtask

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic checkBit(input logic got, input logic exp, input string what);
		assert (got === exp) else
			failRun($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic checkResult(input exResult exp, input int idx);
		assert (result === exp) else
			failRun($sformatf("MISMATCH at %0t: op %0d result %h/%h/%h, expected %h/%h/%h",
				$time, idx, result.destId, result.value, result.heldId,
				exp.destId, exp.value, exp.heldId));
	endtask

	task automatic driveIdle();
		uop         = '{cond: condAlways, cmd: cmdNop, ixt: 8'd0};
		operands    = '0;
		braFlush    = 1'b0;
		statusWrite = 1'b0;
		statusValue = 1'b0;
	endtask

	task automatic applyEntry(input entryT e, input int idx);
		if (e.setT) begin
			@(posedge clock);
			#1;
			driveIdle();
			statusWrite = 1'b1;
			statusValue = e.tVal;
		end
		@(posedge clock);
		#1;
		statusWrite = 1'b0;
		uop         = e.uop;
		operands    = e.ops;
		braFlush    = e.flush;
		#1;
		checkBit(hold, e.expHold, "hold");
		@(posedge clock);
		#1;
		driveIdle();
		checkResult(e.expRes, idx);
		checkBit(tBit, e.expT, "tBit");
		if (e.expHold) begin
			faultSeen = 1'b1;
		end
		checkBit(faultValid, faultSeen, "faultValid");
	endtask

	task automatic waitFaultValid();
		int cycles;
		cycles = 0;
		while (!faultValid) begin
			if (cycles >= 10) begin
				failRun("Timeout: faultValid never rose after a fault");
			end
			@(posedge clock);
			#1;
			cycles++;
		end
	endtask

	task automatic buildTable();
		exOperands ldi;
		exOperands sh;
		exOperands cv;
		ldi = makeOps(64'd0, 64'd0, 64'd0, 33'd5, 6'd5);
		// Predicate with T at 0 and 1, then a flush
		addEntry(1, 0, condAlways, cmdMovIr, 8'h00, ldi, 0, 6'd5, 64'd5, zeroRegId, 0, 0);
		addEntry(1, 1, condAlways, cmdMovIr, 8'h00, ldi, 0, 6'd5, 64'd5, zeroRegId, 0, 1);
		addEntry(1, 0, condNever, cmdMovIr, 8'h00, ldi, 0, zeroRegId, 64'd0, zeroRegId, 0, 0);
		addEntry(1, 1, condNever, cmdMovIr, 8'h00, ldi, 0, zeroRegId, 64'd0, zeroRegId, 0, 1);
		addEntry(1, 0, condTrue, cmdMovIr, 8'h00, ldi, 0, zeroRegId, 64'd0, zeroRegId, 0, 0);
		addEntry(1, 1, condTrue, cmdMovIr, 8'h00, ldi, 0, 6'd5, 64'd5, zeroRegId, 0, 1);
		addEntry(1, 0, condFalse, cmdMovIr, 8'h00, ldi, 0, 6'd5, 64'd5, zeroRegId, 0, 0);
		addEntry(1, 1, condFalse, cmdMovIr, 8'h00, ldi, 0, zeroRegId, 64'd0, zeroRegId, 0, 1);
		addEntry(1, 0, condAlways, cmdMovIr, 8'h00, ldi, 1, zeroRegId, 64'd0, zeroRegId, 0, 0);
		// Moves and immediate forms
		addEntry(1, 0, condAlways, cmdMovRm, 8'h00, makeOps(64'h1111, 0, 0, 0, 6'd5), 0,
			zeroRegId, 64'h1111, zeroRegId, 0, 0);
		addEntry(0, 0, condAlways, cmdPushX, 8'h00, makeOps(0, 0, 64'h2222, 0, 6'd5), 0,
			zeroRegId, 64'h2222, zeroRegId, 0, 0);
		addEntry(0, 0, condAlways, cmdMovIr, 8'h00, makeOps(0, 0, 0, 33'h0_7FFF_FFFF, 6'd7), 0,
			6'd7, 64'h7FFF_FFFF, zeroRegId, 0, 0);
		addEntry(0, 0, condAlways, cmdMovIr, 8'h00, makeOps(0, 0, 0, 33'h1_8000_0000, 6'd7), 0,
			6'd7, 64'hFFFF_FFFF_8000_0000, zeroRegId, 0, 0);
		sh = makeOps(64'h0011_2233_4455_6677, 64'h55, 0, 33'h0_CAFE_BEAB, 6'd8);
		addEntry(0, 0, condAlways, cmdMovIr, 8'h01, sh, 0, 6'd8, 64'h1122_3344_5566_77AB,
			zeroRegId, 0, 0);
		addEntry(0, 0, condAlways, cmdMovIr, 8'h02, sh, 0, 6'd8, 64'h2233_4455_6677_BEAB,
			zeroRegId, 0, 0);
		addEntry(0, 0, condAlways, cmdMovIr, 8'h03, sh, 0, 6'd8, 64'h4455_6677_CAFE_BEAB,
			zeroRegId, 0, 0);
		addEntry(0, 0, condAlways, cmdMovIr, 8'h04, sh, 0, 6'd8, 64'h55, zeroRegId, 0, 0);
		addEntry(0, 0, condAlways, cmdAlu3, 8'h00, makeOps(0, 0, 0, 0, 6'd9), 0,
			zeroRegId, 64'd0, 6'd9, 0, 0);
		addEntry(0, 0, condAlways, cmdUnary, 8'h00, makeOps(0, 0, 0, 0, 6'd10), 0,
			zeroRegId, 64'd0, 6'd10, 0, 0);
		addEntry(0, 0, condAlways, cmdMulw3, 8'h00, makeOps(0, 0, 0, 0, 6'd11), 0,
			zeroRegId, 64'd0, 6'd11, 0, 0);
		// Directed shifts
		addEntry(0, 0, condAlways, cmdShad3, 0, makeOps(64'h8000_0000, 64'hFC, 0, 0, 6'd3), 0,
			6'd3, 64'hFFFF_FFFF_F800_0000, zeroRegId, 0, 0);
		addEntry(0, 0, condAlways, cmdShld3, 0, makeOps(64'h8000_0000, 64'hFC, 0, 0, 6'd3), 0,
			6'd3, 64'h0800_0000, zeroRegId, 0, 0);
		addEntry(0, 0, condAlways, cmdShad3, 0, makeOps(64'h1, 64'h04, 0, 0, 6'd3), 0,
			6'd3, 64'h10, zeroRegId, 0, 0);
		addEntry(0, 0, condAlways, cmdShad3, 0, makeOps(64'h1, 64'd32, 0, 0, 6'd3), 0,
			6'd3, 64'd0, zeroRegId, 0, 0);
		addEntry(0, 0, condAlways, cmdShad3, 0, makeOps(64'h8000_0000, 64'hD8, 0, 0, 6'd3), 0,
			6'd3, '1, zeroRegId, 0, 0);
		addEntry(0, 0, condAlways, cmdShldq3, 0, makeOps(64'h8000_0000_0000_0000, 64'hFF, 0, 0,
			6'd4), 0, 6'd4, 64'h4000_0000_0000_0000, zeroRegId, 0, 0);
		addEntry(0, 0, condAlways, cmdShadq3, 0, makeOps(64'h8000_0000_0000_0000, 64'hFF, 0, 0,
			6'd4), 0, 6'd4, 64'hC000_0000_0000_0000, zeroRegId, 0, 0);
		addEntry(0, 0, condAlways, cmdShadq3, 0, makeOps(64'h1, 64'd64, 0, 0, 6'd4), 0,
			6'd4, 64'd0, zeroRegId, 0, 0);
		addEntry(0, 0, condAlways, cmdShadq3, 0, makeOps(64'h8000_0000_0000_0000, 64'h80, 0, 0,
			6'd4), 0, 6'd4, '1, zeroRegId, 0, 0);
		// Conversions, T preset opposite to the unchanged flag
		cv = makeOps(64'hFFFF_FFFF_FFFF_FF80, 0, 0, 0, 6'd12);
		addEntry(1, 0, condAlways, cmdConvRr, 8'd0, cv, 0, 6'd12, cv.rsVal, zeroRegId, 0, 1);
		addEntry(1, 1, condAlways, cmdConvRr, 8'd1, cv, 0, 6'd12, 64'h80, zeroRegId, 0, 0);
		addEntry(1, 0, condAlways, cmdConvRr, 8'd2, cv, 0, 6'd12, cv.rsVal, zeroRegId, 0, 1);
		addEntry(1, 1, condAlways, cmdConvRr, 8'd3, cv, 0, 6'd12, 64'hFF80, zeroRegId, 0, 0);
		addEntry(1, 0, condAlways, cmdConvRr, 8'd4, cv, 0, 6'd12, cv.rsVal, zeroRegId, 0, 1);
		addEntry(1, 0, condAlways, cmdConvRr, 8'd7, cv, 0, 6'd12, cv.rsVal, zeroRegId, 0, 1);
		addEntry(1, 1, condAlways, cmdConvRr, 8'd5, cv, 0, 6'd12, 64'hFFFF_FF80, zeroRegId, 0, 0);
		addEntry(0, 0, condAlways, cmdOpIxs, 8'h01, cv, 0, 6'd12, 64'd0, zeroRegId, 0, 0);
		addEntry(0, 0, condAlways, cmdOpIxs, 8'h02, cv, 0, 6'd12, 64'd1, zeroRegId, 0, 0);
		addEntry(0, 0, condAlways, cmdConvRr, 8'd6, cv, 0, 6'd12, cv.rsVal, zeroRegId, 0, 1);
		addEntry(0, 0, condAlways, cmdOpIxs, 8'h01, cv, 0, 6'd12, 64'd1, zeroRegId, 0, 1);
		// Faults; the first one is the record to keep
		addEntry(1, 0, condAlways, cmdInvOp, 8'h00, ldi, 0, zeroRegId, 0, zeroRegId, 1, 0);
		addEntry(0, 0, condAlways, cmdOpIxt, 8'h02, ldi, 0, zeroRegId, 0, zeroRegId, 1, 0);
		addEntry(0, 0, condAlways, cmdOpIxs, 8'h05, ldi, 0, zeroRegId, 0, zeroRegId, 1, 0);
		addEntry(0, 0, condAlways, cmdOpIxt, 8'h07, ldi, 0, zeroRegId, 0, zeroRegId, 1, 0);
		addEntry(0, 0, condAlways, 6'h3F, 8'h00, ldi, 0, zeroRegId, 0, zeroRegId, 1, 0);
	endtask

	initial begin
		entryT       e;
		logic [1:0]  sel;
		logic [5:0]  cmd;
		logic [63:0] rs;
		logic [63:0] expVal;
		logic [31:0] rnd;
		reset     = 1'b1;
		faultSeen = 1'b0;
		driveIdle();
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;

		buildTable();
		foreach (entries[i]) begin
			applyEntry(entries[i], i);
		end

		waitFaultValid();
		assert (fault === exFault'{cmd: cmdInvOp, ixt: 8'h00}) else
			failRun($sformatf("MISMATCH at %0t: fault record %h is not the first fault",
				$time, fault));

		// External write alone, then against a lane write at the same edge
		@(posedge clock);
		#1;
		statusWrite = 1'b1;
		statusValue = 1'b1;
		@(posedge clock);
		#1;
		checkBit(tBit, 1'b1, "tBit after external write");
		uop      = '{cond: condAlways, cmd: cmdConvRr, ixt: 8'd1};
		operands = makeOps(64'h133, 0, 0, 0, 6'd2); // Zero byte changes it, lane writes 0
		@(posedge clock);
		#1;
		driveIdle();
		checkBit(tBit, 1'b0, "tBit with lane and external write");

		for (int i = 0; i < 200; i++) begin
			rnd = nextRand();
			sel = rnd[8:7];
			cmd = (sel == 0) ? cmdShad3 : (sel == 1) ? cmdShld3 : (sel == 2) ? cmdShadq3 : cmdShldq3;
			rs  = {nextRand(), nextRand()};
			rnd = nextRand();
			e.setT     = 1'b0;
			e.tVal     = 1'b0;
			e.uop      = '{cond: condAlways, cmd: cmd, ixt: 8'd0};
			e.ops      = makeOps(rs, {56'd0, rnd[16:9]}, 0, 0, 6'd20);
			e.flush    = 1'b0;
			expVal     = shiftModel(rs, e.ops.rtVal[7:0], sel[0] == 1'b0, sel[1] ? 64 : 32);
			e.expRes   = '{destId: 6'd20, value: expVal, heldId: zeroRegId};
			e.expHold  = 1'b0;
			e.expT     = 1'b0; // Shifts leave T as the lane write set it
			applyEntry(e, 1000 + i);
		end

		// Hold stays low in reset, and reset clears the fault record
		@(posedge clock);
		#1;
		reset = 1'b1;
		uop   = '{cond: condAlways, cmd: cmdInvOp, ixt: 8'd0};
		#1;
		checkBit(hold, 1'b0, "hold during reset");
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;
		driveIdle();
		checkBit(faultValid, 1'b0, "faultValid after reset");
		checkBit(tBit, 1'b0, "tBit after reset");
		checkResult(exResult'{destId: zeroRegId, value: 64'd0, heldId: zeroRegId}, 9999);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// ==== project.f ====
logic/exLanePkg.sv
logic/exShifter.sv
logic/exConvert.sv
logic/exStatusReg.sv
logic/exLaneB.sv
logic/exLaneTop.sv
tests/exLaneAsserts.sv
tests/exLaneTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the lane testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wall -Wno-fatal \
	--top-module exLaneTb -f project.f -o exLaneSim
status=$?
if [ $status -ne 0 ]; then
	echo "Compile failed with status $status"
	exit 1
fi

./obj_dir/exLaneSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
	exit 1
fi
if [ $status -ne 0 ]; then
	exit 1
fi
exit 0
